// File: src/rv_isa_pkg.sv
// rv64i isa encodings
package rv_isa_pkg;

    localparam int xlen      = 64;          // gpr and pc width
    localparam int reg_idx_w = 5;

    typedef logic [reg_idx_w-1:0] reg_idx_t;  // x0..x31

    // bit positions inside the 32-bit word
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int funct7_lsb = 25;

    localparam logic [6:0] funct7_base     = 7'b0000000;  // add, srl, sll
    localparam logic [6:0] funct7_alt      = 7'b0100000;  // sub, sra
    localparam logic [2:0] funct3_bad_load = 3'b111;      // unused load slot in rv64

    // major opcode, inst[6:0]
    typedef enum logic [6:0] {
        LOAD      = 7'b0000011,
        STORE     = 7'b0100011,
        BRANCH    = 7'b1100011,
        JALR      = 7'b1100111,
        JAL       = 7'b1101111,
        OP_IMM    = 7'b0010011,
        OP_IMM_32 = 7'b0011011,
        OP        = 7'b0110011,
        OP_32     = 7'b0111011,
        LUI       = 7'b0110111,
        AUIPC     = 7'b0010111
    } major_op_e;

    // immediate layout picked by the decoder
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    // one code per kept instruction, zero is the illegal marker
    typedef enum logic [5:0] {
        OP_ILLEGAL,
        OP_ADD,   OP_SUB,   OP_SLL,   OP_SLT,   OP_SLTU,   // reg-reg
        OP_XOR,   OP_SRL,   OP_SRA,   OP_OR,    OP_AND,
        OP_ADDW,  OP_SUBW,  OP_SLLW,  OP_SRLW,  OP_SRAW,   // 32-bit reg-reg
        OP_ADDI,  OP_SLTI,  OP_SLTIU, OP_XORI,  OP_ORI,    // reg-imm
        OP_ANDI,  OP_SLLI,  OP_SRLI,  OP_SRAI,
        OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,             // 32-bit reg-imm
        OP_LB,    OP_LH,    OP_LW,    OP_LD,               // loads
        OP_LBU,   OP_LHU,   OP_LWU,
        OP_SB,    OP_SH,    OP_SW,    OP_SD,               // stores
        OP_BEQ,   OP_BNE,   OP_BLT,   OP_BGE,              // branches
        OP_BLTU,  OP_BGEU,
        OP_JAL,   OP_JALR,  OP_LUI,   OP_AUIPC
    } rv_op_e;

endpackage

// File: src/decode_pkg.sv
// decode stage packet types
package decode_pkg;
    import rv_isa_pkg::*;

    localparam int inst_w  = 32;   // instruction word
    localparam int num_gpr = 32;   // register file entries

    // what fetch hands over, 96 bits
    typedef struct packed {
        logic [xlen-1:0]   pc;
        logic [inst_w-1:0] inst;
    } fetch_packet_t;

    // decoder result, 10 bits
    typedef struct packed {
        rv_op_e   op;
        imm_fmt_e fmt;
        logic     uses_rs2;     // rs2 is a real source
    } decode_info_t;

    // operands sent to execute, 192 bits
    typedef struct packed {
        logic [xlen-1:0] src_a;  // gpr[rs1]
        logic [xlen-1:0] src_b;  // gpr[rs2]
        logic [xlen-1:0] imm;    // sign-extended
    } operands_t;

endpackage

// File: src/fetch_queue.sv
// fetch packet fifo
`timescale 1ns/1ns
module fetch_queue import decode_pkg::*; #(
    parameter int QUEUE_DEPTH = 16,
    parameter int ALMOST_FULL = 12
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          flush,        // drop all entries
    input  logic          push,
    input  fetch_packet_t push_pkt,
    input  logic          pop,
    output fetch_packet_t head_pkt,     // oldest entry
    output logic          empty,
    output logic          almost_full   // upstream ready is its inverse
);
    localparam int ptr_w = $clog2(QUEUE_DEPTH);
    localparam int cnt_w = $clog2(QUEUE_DEPTH + 1);

    fetch_packet_t    mem [QUEUE_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;            // entries held
    logic             full;

    // wrap for any depth, not only powers of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // idle, or push and pop together
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_pkt;
        end
    end

    assign head_pkt    = mem[rd_ptr];           // first-word fall-through
    assign empty       = (count == '0);
    assign full        = (count == cnt_w'(QUEUE_DEPTH));
    assign almost_full = (count >= cnt_w'(ALMOST_FULL));

    // fetch must respect ready_in, and the slot pops only what is there
    assert property (@(posedge clk) disable iff (reset || flush) push |-> !full);
    assert property (@(posedge clk) disable iff (reset || flush) pop |-> !empty);

endmodule

// File: src/issue_slot.sv
// decode pipeline register
`timescale 1ns/1ns
module issue_slot import decode_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          flush,         // branch redirect
    input  logic          advance,       // slot may load a new packet
    input  logic          queue_empty,
    input  fetch_packet_t head_pkt,
    input  logic          valid_in,
    input  fetch_packet_t in_pkt,
    output logic          pop,           // head moves into the slot
    output logic          slot_valid,
    output fetch_packet_t slot_pkt
);
    // queued packets are older, they always go first
    assign pop = advance && !queue_empty;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            slot_valid <= 1'b0;
        end else if (advance) begin
            slot_valid <= !queue_empty || valid_in;   // bypass when queue is dry
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            slot_pkt <= queue_empty ? in_pkt : head_pkt;
        end
    end

    // only a valid packet is ever held, an empty slot always refills
    assert property (@(posedge clk) disable iff (reset || flush)
        !advance |-> slot_valid);

endmodule

// File: src/load_use_hazard.sv
// load-use interlock
`timescale 1ns/1ns
module load_use_hazard import rv_isa_pkg::*, decode_pkg::*; (
    input  logic              slot_valid,
    input  logic [inst_w-1:0] slot_inst,   // instruction in decode
    input  logic              uses_rs2,
    input  logic              ex_valid,
    input  logic [inst_w-1:0] ex_inst,     // instruction in execute
    output logic              block        // hold decode one more cycle
);
    reg_idx_t ex_rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     ex_load;
    logic     rs1_hit;
    logic     rs2_hit;

    assign ex_rd = ex_inst[rd_lsb +: reg_idx_w];
    assign rs1   = slot_inst[rs1_lsb +: reg_idx_w];
    assign rs2   = slot_inst[rs2_lsb +: reg_idx_w];

    // any rv64 load, data shows up after execute
    assign ex_load = (ex_inst[6:0] == LOAD) &&
                     (ex_inst[funct3_lsb +: 3] != funct3_bad_load);

    assign rs1_hit = (ex_rd == rs1);
    assign rs2_hit = uses_rs2 && (ex_rd == rs2);   // only when rs2 is read

    // x0 never carries a dependency
    assign block = slot_valid && ex_valid && ex_load && (ex_rd != '0) &&
                   (rs1_hit || rs2_hit);

endmodule

// File: src/inst_decoder.sv
// rv64i instruction decoder
`timescale 1ns/1ns
module inst_decoder import rv_isa_pkg::*, decode_pkg::*; (
    input  logic [inst_w-1:0] inst,
    output decode_info_t      info
);
    major_op_e  major;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign major  = major_op_e'(inst[6:0]);
    assign funct3 = inst[funct3_lsb +: 3];
    assign funct7 = inst[funct7_lsb +: 7];

    always_comb begin
        info.op       = OP_ILLEGAL;   // unmatched encodings
        info.fmt      = IMM_I;        // loads, jalr, alu-imm
        info.uses_rs2 = 1'b0;
        case (major)
            LOAD: begin
                case (funct3)
                    3'b000:  info.op = OP_LB;
                    3'b001:  info.op = OP_LH;
                    3'b010:  info.op = OP_LW;
                    3'b011:  info.op = OP_LD;
                    3'b100:  info.op = OP_LBU;
                    3'b101:  info.op = OP_LHU;
                    3'b110:  info.op = OP_LWU;
                    default: info.op = OP_ILLEGAL;
                endcase
            end
            STORE: begin
                info.fmt = IMM_S;
                case (funct3)
                    3'b000:  info.op = OP_SB;
                    3'b001:  info.op = OP_SH;
                    3'b010:  info.op = OP_SW;
                    3'b011:  info.op = OP_SD;
                    default: info.op = OP_ILLEGAL;
                endcase
            end
            BRANCH: begin
                info.fmt      = IMM_B;
                info.uses_rs2 = 1'b1;        // compare needs both sources
                case (funct3)
                    3'b000:  info.op = OP_BEQ;
                    3'b001:  info.op = OP_BNE;
                    3'b100:  info.op = OP_BLT;
                    3'b101:  info.op = OP_BGE;
                    3'b110:  info.op = OP_BLTU;
                    3'b111:  info.op = OP_BGEU;
                    default: info.op = OP_ILLEGAL;
                endcase
            end
            JALR: info.op = (funct3 == 3'b000) ? OP_JALR : OP_ILLEGAL;
            JAL: begin
                info.op  = OP_JAL;
                info.fmt = IMM_J;
            end
            LUI, AUIPC: begin
                info.op  = (major == LUI) ? OP_LUI : OP_AUIPC;
                info.fmt = IMM_U;
            end
            OP_IMM: begin
                case (funct3)
                    3'b000:  info.op = OP_ADDI;
                    3'b010:  info.op = OP_SLTI;
                    3'b011:  info.op = OP_SLTIU;
                    3'b100:  info.op = OP_XORI;
                    3'b110:  info.op = OP_ORI;
                    3'b111:  info.op = OP_ANDI;
                    // 6-bit shamt, funct7[0] belongs to it
                    3'b001:  info.op = (funct7[6:1] == funct7_base[6:1]) ? OP_SLLI : OP_ILLEGAL;
                    3'b101:  info.op = (funct7[6:1] == funct7_base[6:1]) ? OP_SRLI :
                                       (funct7[6:1] == funct7_alt[6:1])  ? OP_SRAI : OP_ILLEGAL;
                    default: info.op = OP_ILLEGAL;
                endcase
            end
            OP_IMM_32: begin
                case (funct3)
                    3'b000:  info.op = OP_ADDIW;
                    3'b001:  info.op = (funct7 == funct7_base) ? OP_SLLIW : OP_ILLEGAL;
                    3'b101:  info.op = (funct7 == funct7_base) ? OP_SRLIW :
                                       (funct7 == funct7_alt)  ? OP_SRAIW : OP_ILLEGAL;
                    default: info.op = OP_ILLEGAL;
                endcase
            end
            OP: begin
                info.uses_rs2 = 1'b1;
                case ({funct7, funct3})
                    {funct7_base, 3'b000}: info.op = OP_ADD;
                    {funct7_alt,  3'b000}: info.op = OP_SUB;
                    {funct7_base, 3'b001}: info.op = OP_SLL;
                    {funct7_base, 3'b010}: info.op = OP_SLT;
                    {funct7_base, 3'b011}: info.op = OP_SLTU;
                    {funct7_base, 3'b100}: info.op = OP_XOR;
                    {funct7_base, 3'b101}: info.op = OP_SRL;
                    {funct7_alt,  3'b101}: info.op = OP_SRA;
                    {funct7_base, 3'b110}: info.op = OP_OR;
                    {funct7_base, 3'b111}: info.op = OP_AND;
                    default:               info.op = OP_ILLEGAL;   // m-ext lands here
                endcase
            end
            OP_32: begin
                info.uses_rs2 = 1'b1;
                case ({funct7, funct3})
                    {funct7_base, 3'b000}: info.op = OP_ADDW;
                    {funct7_alt,  3'b000}: info.op = OP_SUBW;
                    {funct7_base, 3'b001}: info.op = OP_SLLW;
                    {funct7_base, 3'b101}: info.op = OP_SRLW;
                    {funct7_alt,  3'b101}: info.op = OP_SRAW;
                    default:               info.op = OP_ILLEGAL;
                endcase
            end
            default: info.op = OP_ILLEGAL;   // system, fence, csr
        endcase
    end

endmodule

// File: src/operand_gen.sv
// immediate and operand generation
`timescale 1ns/1ns
module operand_gen import rv_isa_pkg::*, decode_pkg::*; (
    input  logic [inst_w-1:0] inst,
    input  imm_fmt_e          fmt,
    input  logic [xlen-1:0]   gpr_file [num_gpr],
    output operands_t         opnds
);
    reg_idx_t        rs1;
    reg_idx_t        rs2;
    logic            sign;
    logic [xlen-1:0] imm;

    assign rs1  = inst[rs1_lsb +: reg_idx_w];
    assign rs2  = inst[rs2_lsb +: reg_idx_w];
    assign sign = inst[inst_w-1];     // every format extends from bit 31

    always_comb begin
        case (fmt)
            IMM_S:   imm = {{(xlen-12){sign}}, inst[31:25], inst[11:7]};
            IMM_B:   imm = {{(xlen-12){sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_U:   imm = {{(xlen-32){sign}}, inst[31:12], 12'b0};
            IMM_J:   imm = {{(xlen-20){sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = {{(xlen-12){sign}}, inst[31:20]};        // i-type
        endcase
    end

    // plain index reads, x0 content comes from the file itself
    assign opnds.src_a = gpr_file[rs1];
    assign opnds.src_b = gpr_file[rs2];
    assign opnds.imm   = imm;

endmodule

// File: src/decode_stage.sv
// rv64 instruction decode stage
`timescale 1ns/1ns
module decode_stage import rv_isa_pkg::*, decode_pkg::*; #(
    parameter int QUEUE_DEPTH = 16,
    parameter int ALMOST_FULL = 12
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid_in,
    input  fetch_packet_t     in_pkt,
    output logic              ready_in,
    input  logic              ready_out,     // execute can take a packet
    output logic              valid_out,
    output fetch_packet_t     out_pkt,
    output rv_op_e            op,
    output operands_t         opnds,
    input  logic              ex_valid,
    input  logic [inst_w-1:0] ex_inst,
    input  logic [xlen-1:0]   gpr_file [num_gpr],
    input  logic              branch_flush
);
    fetch_packet_t head_pkt;
    fetch_packet_t slot_pkt;
    decode_info_t  info;
    logic          queue_empty;
    logic          almost_full;
    logic          slot_valid;
    logic          pop;
    logic          push;
    logic          advance;
    logic          block;

    assign advance   = !slot_valid || (ready_out && !block);   // empty slot always refills
    assign push      = valid_in && !(queue_empty && advance);  // not on bypass
    assign ready_in  = !almost_full;
    assign valid_out = slot_valid && !block;
    assign out_pkt   = slot_pkt;
    assign op        = info.op;

    fetch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH), .ALMOST_FULL(ALMOST_FULL)) u_queue (
        .clk(clk), .reset(reset), .flush(branch_flush),
        .push(push), .push_pkt(in_pkt), .pop(pop),
        .head_pkt(head_pkt), .empty(queue_empty), .almost_full(almost_full)
    );

    issue_slot u_slot (
        .clk(clk), .reset(reset), .flush(branch_flush), .advance(advance),
        .queue_empty(queue_empty), .head_pkt(head_pkt),
        .valid_in(valid_in), .in_pkt(in_pkt),
        .pop(pop), .slot_valid(slot_valid), .slot_pkt(slot_pkt)
    );

    load_use_hazard u_hazard (
        .slot_valid(slot_valid), .slot_inst(slot_pkt.inst), .uses_rs2(info.uses_rs2),
        .ex_valid(ex_valid), .ex_inst(ex_inst), .block(block)
    );

    inst_decoder u_decoder (.inst(slot_pkt.inst), .info(info));

    operand_gen u_operands (
        .inst(slot_pkt.inst), .fmt(info.fmt), .gpr_file(gpr_file), .opnds(opnds)
    );

endmodule

// File: verif/decode_stage_tb.sv
// decode stage testbench
`timescale 1ns/1ns
module decode_stage_tb
    import rv_isa_pkg::*, decode_pkg::*;
();
    localparam int almost_full_lvl = 12;

    logic          clk, reset, valid_in, ready_in, ready_out, valid_out, ex_valid, branch_flush;
    fetch_packet_t in_pkt, out_pkt;
    rv_op_e        op;
    operands_t     opnds;
    logic [31:0]   ex_inst;
    logic [63:0]   gpr_file [32];         // fixed for the whole run

    fetch_packet_t exp_q [$];             // accepted, not yet consumed
    int            value_errors, other_errors, consumed, accepted;
    logic          flushed;               // flush on the last edge

    major_op_e majors [11] = '{LOAD, STORE, BRANCH, JALR, JAL, OP_IMM, OP_IMM_32, OP, OP_32,
                               LUI, AUIPC};
    // expected op per funct3
    rv_op_e load_tbl [8]    = '{OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU, OP_ILLEGAL};
    rv_op_e store_tbl [8]   = '{OP_SB, OP_SH, OP_SW, OP_SD, OP_ILLEGAL, OP_ILLEGAL, OP_ILLEGAL,
                                OP_ILLEGAL};
    rv_op_e branch_tbl [8]  = '{OP_BEQ, OP_BNE, OP_ILLEGAL, OP_ILLEGAL, OP_BLT, OP_BGE, OP_BLTU,
                                OP_BGEU};
    rv_op_e alu_imm_tbl [8] = '{OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU, OP_XORI, OP_SRLI, OP_ORI,
                                OP_ANDI};
    rv_op_e alu_tbl [8]     = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_OR, OP_AND};

    decode_stage #(.QUEUE_DEPTH(16), .ALMOST_FULL(almost_full_lvl)) UUT (.*);

    always #4 clk = ~clk;                 // 8 ns period

    function automatic rv_op_e expected_op(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            7'h03: return load_tbl[f3];
            7'h23: return store_tbl[f3];
            7'h63: return branch_tbl[f3];
            7'h67: return (f3 == 3'd0) ? OP_JALR : OP_ILLEGAL;
            7'h6f: return OP_JAL;
            7'h37: return OP_LUI;
            7'h17: return OP_AUIPC;
            7'h13: begin                   // shamt is 6 bits wide here
                if (f3 == 3'd5 && w[31:26] == 6'h10) return OP_SRAI;
                if ((f3 == 3'd1 || f3 == 3'd5) && w[31:26] != 6'h00) return OP_ILLEGAL;
                return alu_imm_tbl[f3];
            end
            7'h1b: begin
                if (f3 == 3'd0) return OP_ADDIW;
                if (f3 == 3'd1 && f7 == 7'h00) return OP_SLLIW;
                if (f3 == 3'd5 && f7 == 7'h00) return OP_SRLIW;
                if (f3 == 3'd5 && f7 == 7'h20) return OP_SRAIW;
                return OP_ILLEGAL;
            end
            7'h33: begin
                if (f7 == 7'h00) return alu_tbl[f3];
                if (f7 == 7'h20 && f3 == 3'd0) return OP_SUB;
                if (f7 == 7'h20 && f3 == 3'd5) return OP_SRA;
                return OP_ILLEGAL;
            end
            7'h3b: begin
                if (f7 == 7'h00 && f3 == 3'd0) return OP_ADDW;
                if (f7 == 7'h20 && f3 == 3'd0) return OP_SUBW;
                if (f7 == 7'h00 && f3 == 3'd1) return OP_SLLW;
                if (f7 == 7'h00 && f3 == 3'd5) return OP_SRLW;
                if (f7 == 7'h20 && f3 == 3'd5) return OP_SRAW;
                return OP_ILLEGAL;
            end
            default: return OP_ILLEGAL;
        endcase
    endfunction

    function automatic logic [63:0] expected_imm(input logic [31:0] w);
        logic signed [63:0] v;
        case (w[6:0])
            7'h23:        v = $signed({w[31:25], w[11:7]});                      // store
            7'h63:        v = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});   // branch
            7'h37, 7'h17: v = $signed({w[31:12], 12'h000});                      // lui, auipc
            7'h6f:        v = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0}); // jal
            default:      v = $signed(w[31:20]);
        endcase
        return v;
    endfunction

    function automatic logic reads_rs2(input logic [31:0] w);
        return w[6:0] inside {7'h63, 7'h33, 7'h3b};   // branch, op, op-32
    endfunction

    // current execute inputs against a packet in decode
    function automatic logic load_use_hit(input logic [31:0] w);
        logic [4:0] rd;
        logic       is_load;
        rd      = ex_inst[11:7];
        is_load = (ex_inst[6:0] == 7'h03) && (ex_inst[14:12] != 3'b111);
        return ex_valid && is_load && (rd != 5'd0) &&
               (rd == w[19:15] || (reads_rs2(w) && rd == w[24:20]));
    endfunction

    function automatic logic [31:0] random_inst();
        logic [31:0] w;
        w = $urandom;
        if ($urandom_range(9) != 0) begin  // one in ten stays raw, mostly illegal
            w[6:0] = majors[$urandom_range(10)];
            case ($urandom_range(3))
                0:       w[31:25] = 7'h00;
                1:       w[31:25] = 7'h20;
                default: ;
            endcase
        end
        return w;
    endfunction

    function automatic logic [31:0] random_ex_inst();
        logic [31:0] w;
        w = random_inst();
        if ($urandom_range(9) < 6) begin   // mostly loads aimed at the head's sources
            w[6:0] = 7'h03;
            if (exp_q.size() != 0)
                w[11:7] = $urandom_range(1) ? exp_q[0].inst[19:15] : exp_q[0].inst[24:20];
        end
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        value_errors++;
        $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want);
    endtask

    task automatic note_failure(input string what);
        other_errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic check_outputs();
        fetch_packet_t exp;
        if (flushed && valid_out) note_failure("valid_out high in the cycle after a flush");
        if (valid_out && exp_q.size() == 0) note_failure("valid_out high with nothing pending");
        if (!valid_out && exp_q.size() != 0 && !load_use_hit(exp_q[0].inst))
            report_mismatch("valid_out", valid_out, 1'b1);   // head pending, no interlock
        if (valid_out && exp_q.size() != 0) begin
            exp = exp_q[0];
            if (load_use_hit(exp.inst)) note_failure("valid_out high during a load-use hazard");
            if (ready_out) begin           // consumed on the coming edge
                if (out_pkt.pc !== exp.pc) report_mismatch("out_pkt.pc", out_pkt.pc, exp.pc);
                if (out_pkt.inst !== exp.inst)
                    report_mismatch("out_pkt.inst", out_pkt.inst, exp.inst);
                if (op !== expected_op(exp.inst)) report_mismatch("op", op, expected_op(exp.inst));
                if (opnds.imm !== expected_imm(exp.inst))
                    report_mismatch("opnds.imm", opnds.imm, expected_imm(exp.inst));
                if (opnds.src_a !== gpr_file[exp.inst[19:15]])
                    report_mismatch("opnds.src_a", opnds.src_a, gpr_file[exp.inst[19:15]]);
                if (opnds.src_b !== gpr_file[exp.inst[24:20]])
                    report_mismatch("opnds.src_b", opnds.src_b, gpr_file[exp.inst[24:20]]);
                void'(exp_q.pop_front());
                consumed++;
            end
        end
    endtask

    // one clock: drive on the falling edge, check before the rising edge
    task automatic run_cycle(input int p_valid, input int p_ready, input int p_ex, input int p_flush);
        @(negedge clk);
        branch_flush = ($urandom_range(99) < p_flush);
        valid_in     = ready_in && !branch_flush && ($urandom_range(99) < p_valid);
        in_pkt.pc    = {$urandom, $urandom};
        in_pkt.inst  = random_inst();
        ready_out    = ($urandom_range(99) < p_ready);
        ex_valid     = ($urandom_range(99) < p_ex);
        ex_inst      = random_ex_inst();
        #2;
        check_outputs();
        if (branch_flush) begin
            exp_q.delete();                // everything unconsumed is dropped
        end else if (valid_in) begin
            exp_q.push_back(in_pkt);
            accepted++;
        end
        flushed = branch_flush;
    endtask

    initial begin
        int guard;
        void'($urandom(32'hb40d));
        clk          = 1'b0;
        reset        = 1'b1;
        valid_in     = 1'b0;
        in_pkt       = '0;
        ready_out    = 1'b0;
        ex_valid     = 1'b0;
        ex_inst      = '0;
        branch_flush = 1'b0;
        flushed      = 1'b0;
        value_errors = 0;
        other_errors = 0;
        consumed     = 0;
        accepted     = 0;
        foreach (gpr_file[i]) gpr_file[i] = {$urandom, $urandom};
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        if (valid_out !== 1'b0) report_mismatch("valid_out", valid_out, 1'b0);
        if (ready_in !== 1'b1) report_mismatch("ready_in", ready_in, 1'b1);

        // stalled execute, fill until ready_in drops
        guard = 0;
        while (ready_in && guard < 64) begin
            run_cycle(100, 0, 0, 0);
            guard++;
        end
        if (accepted != almost_full_lvl + 1)   // slot plus queue up to the threshold
            report_mismatch("accepted count", accepted, almost_full_lvl + 1);
        guard = 0;
        while (!ready_in && guard < 64) begin
            run_cycle(0, 100, 0, 0);
            guard++;
        end
        if (!ready_in) note_failure("ready_in did not rise again after consumption");

        repeat (3000) run_cycle(60, 70, 50, 2);
        repeat (1500) run_cycle(90, 25, 30, 1);   // heavy back-pressure

        guard = 0;
        while (exp_q.size() != 0 && guard < 400) begin
            run_cycle(0, 100, 0, 0);
            guard++;
        end
        if (exp_q.size() != 0)
            note_failure($sformatf("timed out draining, %0d packets never came out", exp_q.size()));
        repeat (4) run_cycle(0, 100, 0, 0);      // nothing extra may appear

        $display("checked %0d packets: %0d value errors, %0d other errors",
                 consumed, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: riscv_decode.f
src/rv_isa_pkg.sv
src/decode_pkg.sv
src/fetch_queue.sv
src/issue_slot.sv
src/load_use_hazard.sv
src/inst_decoder.sv
src/operand_gen.sv
src/decode_stage.sv
verif/decode_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the decode stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module decode_stage_tb \
    -f riscv_decode.f -Mdir obj_dir -o sim_decode > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_decode > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0
